//--- design/ahb_defs.svh
// bus arbiter configuration macros
`ifndef AHB_DEFS_SVH
`define AHB_DEFS_SVH

// ========================================
// master side
// ========================================

// number of requesting masters
`define AHB_MASTERS 4

// number of priority levels, highest level wins
`define AHB_PRIOR_LEVELS 4

// ========================================
// bus widths
// ========================================

`define AHB_ADDR_W 32
`define AHB_DATA_W 32

`endif

//--- design/ahb_bus_pkg.sv
// bus-side types and burst encoding
`include "ahb_defs.svh"

package ahb_bus_pkg;

  // hburst codes in bus encoding order
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } burst_type;

  // address-phase control word
  typedef struct packed {
    logic [`AHB_ADDR_W-1:0] haddr;
    logic                   hwrite;
    burst_type              hburst;
  } ahb_ctrl_t;

  typedef logic [`AHB_DATA_W-1:0] ahb_data_t;

  // undefined-length INCR is handled as a single beat
  function automatic logic [4:0] burst_beats(burst_type b);
    logic [4:0] n;
    case (b)
      WRAP4, INCR4:   n = 5'd4;
      WRAP8, INCR8:   n = 5'd8;
      WRAP16, INCR16: n = 5'd16;
      default:        n = 5'd1;
    endcase
    return n;
  endfunction

endpackage

//--- design/arb_pkg.sv
// arbitration-side types
`include "ahb_defs.svh"

package arb_pkg;

  // one priority level per master
  typedef logic [$clog2(`AHB_PRIOR_LEVELS)-1:0] prior_t;

  // ========================================
  // burst lock control
  // ========================================

  // idle means the grant may move on an accepted beat
  typedef enum logic {
    LOCK_IDLE  = 1'b0,
    LOCK_BURST = 1'b1
  } lock_state_t;

  // remaining beats, up to 16
  typedef logic [4:0] beat_cnt_t;

endpackage

//--- design/prior_grant_arbiter.sv
// dynamic priority grant arbiter
`timescale 1ns/1ps
`include "ahb_defs.svh"

module prior_grant_arbiter (
  input  logic                                     hclk,
  input  logic                                     hreset_n,
  input  logic [`AHB_MASTERS-1:0]                  hreq,
  input  arb_pkg::prior_t [`AHB_MASTERS-1:0]       hprior,
  input  logic                                     grant_load,
  input  logic                                     beat_accept,
  output logic [`AHB_MASTERS-1:0]                  grant,
  output logic [`AHB_MASTERS-1:0]                  data_grant
);

  import arb_pkg::*;

  // requests at the level being scanned
  logic [`AHB_MASTERS-1:0] level_req;
  // requests of the highest non-empty level
  logic [`AHB_MASTERS-1:0] top_req;
  logic                    level_hit;
  logic [`AHB_MASTERS-1:0] winner;

  // ========================================
  // request selection
  // ========================================

  // scan from the top level down, first non-empty level wins
  always_comb
  begin
    level_hit = 1'b0;
    top_req   = '0;
    level_req = '0;
    for (int lvl = `AHB_PRIOR_LEVELS - 1; lvl >= 0; lvl--)
    begin
      for (int m = 0; m < `AHB_MASTERS; m++)
      begin
        level_req[m] = hreq[m] && (hprior[m] == prior_t'(lvl));
      end
      if (!level_hit && (|level_req))
      begin
        level_hit = 1'b1;
        top_req   = level_req;
      end
    end
  end

  // lowest set bit breaks ties toward master 0
  assign winner = top_req & (~top_req + 1'b1);

  // ========================================
  // grant registers
  // ========================================

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
      grant <= '0;
    else if (grant_load)
      grant <= winner;
  end

  // data phase follows the address phase by one accepted beat
  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
      data_grant <= '0;
    else if (beat_accept)
      data_grant <= grant;
    else if (grant == '0)
      data_grant <= '0;
  end

  // at most one master owns the slave
  a_grant_onehot: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    $onehot0(grant)
  );

  // grant moves only when the lock FSM allows it
  a_grant_hold: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    !grant_load |=> $stable(grant)
  );

endmodule

//--- design/burst_beat_counter.sv
// remaining burst beat counter
`timescale 1ns/1ps

module burst_beat_counter (
  input  logic               hclk,
  input  logic               hreset_n,
  input  logic               ld_cnt,
  input  arb_pkg::beat_cnt_t load_value,
  input  logic               dec_cnt,
  output logic               last_beat,
  output logic               count_zero
);

  import arb_pkg::*;

  beat_cnt_t count;

  // load takes the beats left after the first one
  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
      count <= '0;
    else if (ld_cnt)
      count <= load_value;
    else if (dec_cnt)
      count <= count - 1'b1;
  end

  // one beat left in the burst
  assign last_beat  = (count == beat_cnt_t'(1));
  assign count_zero = (count == '0);

  // ========================================
  // checks
  // ========================================

  a_no_underflow: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    dec_cnt |-> !count_zero
  );

  // a new burst starts only after the previous one drained
  a_load_when_empty: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    ld_cnt |-> count_zero
  );

endmodule

//--- design/burst_lock_fsm.sv
// burst lock control FSM
`timescale 1ns/1ps

module burst_lock_fsm (
  input  logic                  hclk,
  input  logic                  hreset_n,
  input  logic                  hsel,
  input  logic                  hwait,
  input  ahb_bus_pkg::burst_type burst,
  input  logic                  last_beat,
  output logic                  grant_load,
  output logic                  ld_cnt,
  output arb_pkg::beat_cnt_t    load_value,
  output logic                  dec_cnt,
  output logic                  beat_accept
);

  import ahb_bus_pkg::*;
  import arb_pkg::*;

  lock_state_t state;
  lock_state_t next_state;
  logic [4:0]  beats;
  logic        multi_beat;

  assign beat_accept = hsel && !hwait;
  assign beats       = burst_beats(burst);
  assign multi_beat  = (beats != 5'd1);

  always_comb
  begin
    next_state = state;
    grant_load = 1'b0;
    ld_cnt     = 1'b0;
    dec_cnt    = 1'b0;
    load_value = '0;
    case (state)
      LOCK_IDLE:
      begin
        // stalled beats and the first beat of a fixed burst keep the grant
        grant_load = !hsel || (!hwait && !multi_beat);
        if (beat_accept && multi_beat)
        begin
          ld_cnt     = 1'b1;
          load_value = beat_cnt_t'(beats - 5'd1);
          next_state = LOCK_BURST;
        end
      end
      LOCK_BURST:
      begin
        dec_cnt = beat_accept;
        if (beat_accept && last_beat)
        begin
          grant_load = 1'b1;
          next_state = LOCK_IDLE;
        end
      end
      default: next_state = LOCK_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
      state <= LOCK_IDLE;
    else
      state <= next_state;
  end

  a_burst_needs_length: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    $rose(state == LOCK_BURST) |-> !($past(burst) inside {SINGLE, INCR})
  );

endmodule

//--- design/grant_payload_mux.sv
// one-hot payload select
`timescale 1ns/1ps
`include "ahb_defs.svh"

module grant_payload_mux #(
  parameter type payload_t = logic [`AHB_DATA_W-1:0]
) (
  input  logic [`AHB_MASTERS-1:0]     sel,
  input  payload_t [`AHB_MASTERS-1:0] payload_in,
  output payload_t                    payload_out
);

  localparam int payload_w = $bits(payload_t);

  logic [payload_w-1:0] acc;

  // ========================================
  // and-or select
  // ========================================

  // zero select gives a zero payload
  always_comb
  begin
    acc = '0;
    for (int i = 0; i < `AHB_MASTERS; i++)
    begin
      acc = acc | ({payload_w{sel[i]}} & payload_in[i]);
    end
  end

  assign payload_out = payload_t'(acc);

endmodule

//--- design/ahb_slave_arbiter.sv
// slave-side bus arbiter
`timescale 1ns/1ps
`include "ahb_defs.svh"

module ahb_slave_arbiter (
  input  logic                                  hclk,
  input  logic                                  hreset_n,
  input  logic [`AHB_MASTERS-1:0]               hreq,
  input  arb_pkg::prior_t [`AHB_MASTERS-1:0]    hprior,
  input  ahb_bus_pkg::ahb_ctrl_t [`AHB_MASTERS-1:0] m_hctrl,
  input  ahb_bus_pkg::ahb_data_t [`AHB_MASTERS-1:0] m_hwdata,
  input  logic                                  hwait,
  output logic [`AHB_MASTERS-1:0]               hgrant,
  output logic                                  hsel,
  output ahb_bus_pkg::ahb_ctrl_t                s_hctrl,
  output ahb_bus_pkg::ahb_data_t                s_hwdata
);

  import ahb_bus_pkg::*;
  import arb_pkg::*;

  logic [`AHB_MASTERS-1:0] grant;
  logic [`AHB_MASTERS-1:0] data_grant;
  logic                    grant_load;
  logic                    beat_accept;
  logic                    ld_cnt;
  logic                    dec_cnt;
  beat_cnt_t               load_value;
  logic                    last_beat;
  logic                    count_zero;

  assign hgrant = grant;
  assign hsel   = |grant;

  prior_grant_arbiter i_arbiter (
    .hclk(hclk), .hreset_n(hreset_n), .hreq(hreq), .hprior(hprior),
    .grant_load(grant_load), .beat_accept(beat_accept),
    .grant(grant), .data_grant(data_grant)
  );

  // burst code comes from the granted master
  burst_lock_fsm i_lock_fsm (
    .hclk(hclk), .hreset_n(hreset_n), .hsel(hsel), .hwait(hwait),
    .burst(s_hctrl.hburst), .last_beat(last_beat), .grant_load(grant_load),
    .ld_cnt(ld_cnt), .load_value(load_value), .dec_cnt(dec_cnt),
    .beat_accept(beat_accept)
  );

  burst_beat_counter i_beat_counter (
    .hclk(hclk), .hreset_n(hreset_n), .ld_cnt(ld_cnt), .load_value(load_value),
    .dec_cnt(dec_cnt), .last_beat(last_beat), .count_zero(count_zero)
  );

  grant_payload_mux #(.payload_t(ahb_ctrl_t)) i_ctrl_mux (
    .sel(grant), .payload_in(m_hctrl), .payload_out(s_hctrl)
  );

  grant_payload_mux #(.payload_t(ahb_data_t)) i_wdata_mux (
    .sel(data_grant), .payload_in(m_hwdata), .payload_out(s_hwdata)
  );

  // ========================================
  // cross-block checks
  // ========================================

  // an idle bus never leaves beats in the counter
  a_idle_counter_empty: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    !hsel |-> count_zero
  );

  a_stall_keeps_grant: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    (hsel && hwait) |=> $stable(hgrant)
  );

endmodule

//--- dv/arb_clk_gen.sv
// testbench clock and reset source
`timescale 1ns/1ps

module arb_clk_gen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 8
) (
  output logic hclk,
  output logic hreset_n
);

  initial
  begin
    hclk = 1'b0;
    forever #(period_ns / 2) hclk = ~hclk;
  end

  // release lands just after a rising edge, like the stimulus
  initial
  begin
    hreset_n = 1'b0;
    repeat (reset_cycles) @(posedge hclk);
    #2;
    hreset_n = 1'b1;
  end

endmodule

//--- dv/tb_ahb_slave_arbiter.sv
// bus arbiter directed testbench
`timescale 1ns/1ps
`include "ahb_defs.svh"

module tb_ahb_slave_arbiter;

  import ahb_bus_pkg::*;
  import arb_pkg::*;

  localparam int     n_m       = `AHB_MASTERS;
  localparam int     drive_ns  = 2;
  localparam int     num_tests = 5;
  localparam int     limit_ns  = num_tests * 400 * 20;
  localparam prior_t top_level = prior_t'(`AHB_PRIOR_LEVELS - 1);

  logic                         hclk;
  logic                         hreset_n;
  logic [n_m-1:0]               hreq;
  prior_t [n_m-1:0]             hprior;
  ahb_ctrl_t [n_m-1:0]          m_hctrl;
  ahb_data_t [n_m-1:0]          m_hwdata;
  logic                         hwait;
  logic [n_m-1:0]               hgrant;
  logic                         hsel;
  ahb_ctrl_t                    s_hctrl;
  ahb_data_t                    s_hwdata;

  // reference model state
  logic [n_m-1:0] exp_grant;
  logic [n_m-1:0] exp_owner;
  logic           exp_locked;
  int             exp_left;

  int error_count = 0;
  int tests_run   = 0;

  arb_clk_gen i_clk_gen (.hclk(hclk), .hreset_n(hreset_n));

  ahb_slave_arbiter i_ahb_slave_arbiter (
    .hclk(hclk), .hreset_n(hreset_n), .hreq(hreq), .hprior(hprior),
    .m_hctrl(m_hctrl), .m_hwdata(m_hwdata), .hwait(hwait),
    .hgrant(hgrant), .hsel(hsel), .s_hctrl(s_hctrl), .s_hwdata(s_hwdata)
  );

  // ========================================
  // reference model
  // ========================================

  // highest level first, then lowest index
  function automatic logic [n_m-1:0] pick_winner(logic [n_m-1:0] req, prior_t [n_m-1:0] prio);
    int             best;
    logic [n_m-1:0] onehot;
    best   = -1;
    onehot = '0;
    for (int m = 0; m < n_m; m++)
    begin
      if (req[m] && (best < 0 || prio[m] > prio[(best < 0) ? 0 : best]))
        best = m;
    end
    if (best >= 0)
      onehot[best] = 1'b1;
    return onehot;
  endfunction

  // undefined-length INCR counts as one beat
  function automatic int burst_len(burst_type b);
    case (b)
      WRAP4, INCR4:   return 4;
      WRAP8, INCR8:   return 8;
      WRAP16, INCR16: return 16;
      default:        return 1;
    endcase
  endfunction

  always @(posedge hclk or negedge hreset_n)
  begin : ref_model
    logic accept;
    logic load;
    int   len;
    if (!hreset_n)
    begin
      exp_grant  <= '0;
      exp_owner  <= '0;
      exp_locked <= 1'b0;
      exp_left   <= 0;
    end
    else
    begin
      accept = (exp_grant != '0) && !hwait;
      len    = 1;
      for (int m = 0; m < n_m; m++)
        if (exp_grant[m])
          len = burst_len(m_hctrl[m].hburst);
      load = (exp_grant == '0) || (!exp_locked && accept && len == 1)
          || (exp_locked && accept && exp_left == 1);
      if (!exp_locked && accept && len > 1)
      begin
        exp_locked <= 1'b1;
        exp_left   <= len - 1;
      end
      else if (exp_locked && accept)
      begin
        exp_left   <= exp_left - 1;
        exp_locked <= (exp_left != 1);
      end
      if (load)
        exp_grant <= pick_winner(hreq, hprior);
      if (accept)
        exp_owner <= exp_grant;
      else if (exp_grant == '0)
        exp_owner <= '0;
    end
  end

  // ========================================
  // helpers
  // ========================================

  task automatic check_value(input logic [63:0] got, input logic [63:0] want, input string what);
    assert (got === want) else
    begin
      error_count++;
      $display("ERROR %0t ns: %s got %0h expected %0h", $time, what, got, want);
    end
  endtask

  task automatic next_drive_slot();
    @(posedge hclk);
    #(drive_ns);
  endtask

  // drop all requests and let a locked burst drain
  task automatic release_bus();
    int waited;
    waited = 0;
    next_drive_slot();
    hreq  = '0;
    hwait = 1'b0;
    while (hgrant != '0 && waited < 40)
    begin
      next_drive_slot();
      waited++;
    end
    if (hgrant != '0)
    begin
      error_count++;
      $display("the bus stayed granted after all requests were dropped");
    end
    next_drive_slot();
  endtask

  // grant compared with the model every cycle
  always @(negedge hclk)
  begin
    if (hreset_n)
      check_value(hgrant, exp_grant, "hgrant against the model");
  end

  // ========================================
  // directed tests
  // ========================================

  task automatic check_reset_values();
    tests_run++;
    hreq = '1;
    for (int m = 0; m < n_m; m++)
      hprior[m] = prior_t'(m);
    repeat (4)
    begin
      @(negedge hclk);
      check_value(hgrant, '0, "hgrant in reset");
      check_value(hsel, '0, "hsel in reset");
    end
    wait (hreset_n === 1'b1);
    #1;
    check_value(hgrant, '0, "hgrant after reset");
    check_value(hsel, '0, "hsel after reset");
    release_bus();
  endtask

  task automatic priority_case(input logic [n_m-1:0] req, input prior_t [n_m-1:0] prio);
    next_drive_slot();
    hreq   = req;
    hprior = prio;
    hwait  = 1'b0;
    for (int m = 0; m < n_m; m++)
      m_hctrl[m] = '{haddr: $urandom, hwrite: 1'b0, hburst: SINGLE};
    @(negedge hclk);
    @(negedge hclk);
    check_value(hgrant, pick_winner(req, prio), "priority winner");
    release_bus();
  endtask

  task automatic check_priority_select();
    prior_t [n_m-1:0] prio;
    logic [n_m-1:0]   req;
    tests_run++;
    for (int m = 0; m < n_m; m++)
      prio[m] = prior_t'(m);
    priority_case('1, prio);
    for (int m = 0; m < n_m; m++)
      prio[m] = prior_t'(n_m - 1 - m);
    priority_case('1, prio);
    // ties at the top level
    prio = {n_m{top_level}};
    priority_case('1, prio);
    priority_case({{(n_m - 1){1'b1}}, 1'b0}, prio);
    repeat (8)
    begin
      req = $urandom;
      if (req == '0)
        req[0] = 1'b1;
      for (int m = 0; m < n_m; m++)
        prio[m] = prior_t'($urandom % `AHB_PRIOR_LEVELS);
      priority_case(req, prio);
    end
  endtask

  task automatic check_stall_hold();
    logic [n_m-1:0] held;
    logic [n_m-1:0] rival;
    int             stall;
    tests_run++;
    held         = '0;
    held[1]      = 1'b1;
    rival        = '0;
    rival[n_m-1] = 1'b1;
    stall        = 1 + ($urandom % 8);
    next_drive_slot();
    hreq       = held;
    hprior     = '0;
    hwait      = 1'b1;
    m_hctrl[1] = '{haddr: $urandom, hwrite: 1'b1, hburst: SINGLE};
    @(negedge hclk);
    @(negedge hclk);
    check_value(hgrant, held, "grant of the stalled master");
    // higher level arrives while the beat waits
    next_drive_slot();
    hreq          = held | rival;
    hprior[n_m-1] = top_level;
    repeat (stall)
    begin
      @(negedge hclk);
      check_value(hgrant, held, "hgrant during a stalled beat");
      next_drive_slot();
    end
    hreq  = rival;
    hwait = 1'b0;
    @(negedge hclk);
    check_value(hgrant, held, "hgrant before the beat is accepted");
    @(negedge hclk);
    check_value(hgrant, rival, "hgrant after the accepted beat");
    release_bus();
  endtask

  task automatic burst_lock_case(input burst_type b);
    logic [n_m-1:0] owner;
    logic [n_m-1:0] rival;
    int             accepted;
    int             cycles;
    logic           took;
    owner        = '0;
    owner[0]     = 1'b1;
    rival        = '0;
    rival[n_m-1] = 1'b1;
    accepted     = 0;
    cycles       = 0;
    next_drive_slot();
    hreq       = owner;
    hprior     = '0;
    hwait      = 1'b0;
    m_hctrl[0] = '{haddr: $urandom, hwrite: 1'b1, hburst: b};
    next_drive_slot();
    hreq          = owner | rival;
    hprior[n_m-1] = top_level;
    while (accepted < burst_len(b) && cycles < 100)
    begin
      hwait = ($urandom % 3) == 0;
      @(negedge hclk);
      check_value(hgrant, owner, "hgrant during a locked burst");
      took = (hgrant == owner) && !hwait;
      next_drive_slot();
      if (took)
        accepted++;
      cycles++;
    end
    if (accepted < burst_len(b))
    begin
      error_count++;
      $display("burst %s did not complete its beats in time", b.name());
    end
    hreq  = rival;
    hwait = 1'b0;
    @(negedge hclk);
    check_value(hgrant, rival, "hgrant after the burst ended");
    release_bus();
  endtask

  task automatic check_burst_lock();
    burst_type kinds[3];
    kinds = '{INCR4, WRAP8, INCR16};
    tests_run++;
    foreach (kinds[k])
      burst_lock_case(kinds[k]);
  endtask

  task automatic check_payload_routing();
    ahb_ctrl_t want_ctrl;
    ahb_data_t want_data;
    tests_run++;
    repeat (80)
    begin
      next_drive_slot();
      hreq  = $urandom;
      hwait = ($urandom % 4) == 0;
      for (int m = 0; m < n_m; m++)
      begin
        hprior[m]   = prior_t'($urandom % `AHB_PRIOR_LEVELS);
        m_hctrl[m]  = '{haddr: $urandom, hwrite: $urandom % 2,
                        hburst: burst_type'($urandom % 8)};
        m_hwdata[m] = $urandom;
      end
      @(negedge hclk);
      want_ctrl = '0;
      want_data = '0;
      for (int m = 0; m < n_m; m++)
      begin
        if (exp_grant[m])
          want_ctrl = m_hctrl[m];
        if (exp_owner[m])
          want_data = m_hwdata[m];
      end
      check_value(s_hctrl, want_ctrl, "s_hctrl of the granted master");
      check_value(s_hwdata, want_data, "s_hwdata of the data-phase owner");
      check_value(hsel, |exp_grant, "hsel");
    end
    release_bus();
  endtask

  initial
  begin
    hreq     = '0;
    hprior   = '0;
    m_hctrl  = '0;
    m_hwdata = '0;
    hwait    = 1'b0;
    void'($urandom(78));
    check_reset_values();
    check_priority_select();
    check_stall_hold();
    check_burst_lock();
    check_payload_routing();
    $display("tests run: %0d, errors: %0d", tests_run, error_count);
    if (error_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin : watchdog
    #(limit_ns);
    $display("timeout: the tests did not finish within %0d ns", limit_ns);
    $display("Test failed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+design
design/ahb_bus_pkg.sv
design/arb_pkg.sv
design/prior_grant_arbiter.sv
design/burst_beat_counter.sv
design/burst_lock_fsm.sv
design/grant_payload_mux.sv
design/ahb_slave_arbiter.sv
dv/arb_clk_gen.sv
dv/tb_ahb_slave_arbiter.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the arbiter testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_ahb_slave_arbiter -o tb_ahb_slave_arbiter
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_ahb_slave_arbiter 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# the simulation result comes from its own output
if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1
